// File: all.f
+incdir+design
+incdir+tb
design/rv32i_types.sv
design/pipe_ctrl_types.sv
design/control_unit.sv
design/regfile.sv
design/alu.sv
design/load_align.sv
design/datapath.sv
tb/datapath_tb.sv

// File: tb/rv32i_ref_model.svh
`ifndef RV32I_REF_MODEL_SVH
`define RV32I_REF_MODEL_SVH

// instruction encoders
function automatic logic [31:0] enc_i(logic [11:0] imm, logic [4:0] rs1, logic [2:0] f3,
                                      logic [4:0] rd, logic [6:0] op);
    return {imm, rs1, f3, rd, op};
endfunction

function automatic logic [31:0] enc_s(logic [11:0] imm, logic [4:0] rs2, logic [4:0] rs1,
                                      logic [2:0] f3);
    return {imm[11:5], rs2, rs1, f3, imm[4:0], 7'b0100011};
endfunction

function automatic logic [31:0] enc_b(logic [12:0] imm, logic [4:0] rs2, logic [4:0] rs1,
                                      logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
endfunction

function automatic logic [31:0] enc_j(logic [20:0] imm, logic [4:0] rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
endfunction

function automatic logic [31:0] byte_mask(logic [3:0] mbe);
    return {{8{mbe[3]}}, {8{mbe[2]}}, {8{mbe[1]}}, {8{mbe[0]}}};
endfunction

// memory contents before the program is written
function automatic logic [31:0] fill_word(int idx);
    logic [31:0] a;
    a = idx;
    return (a * 32'h9e37_79b1) ^ (a << 7) ^ 32'h5a5a_0000;
endfunction

task automatic emit(logic [31:0] inst);
    mem[gen_pos] = inst;
    gen_pos++;
endtask

task automatic emit_nops(int n);
    for (int i = 0; i < n; i++)
        emit(`NOP_INST);
endtask

// writer, spacing nops, then the result goes to memory
task automatic emit_writer(logic [31:0] inst);
    emit(inst);
    emit_nops(3);
    emit(enc_s(12'(4 * ($urandom % 64)), inst[11:7], 5'd1, 3'b010));
endtask

// three x0-sourced addi, wrong path if the jump is taken
task automatic emit_shadow();
    for (int i = 0; i < 3; i++)
        emit(enc_i(12'($urandom), 5'd0, 3'b000, 5'(2 + $urandom % 30), 7'b0010011));
    emit_nops(3);
endtask

task automatic gen_program();
    int kind;
    logic [2:0] f3;
    logic [4:0] rd;
    logic [11:0] imm;
    logic [2:0] br_codes [6];
    br_codes = '{3'd0, 3'd1, 3'd4, 3'd5, 3'd6, 3'd7};
    gen_pos = 0;
    emit({20'h00004, 5'd1, 7'b0110111});  // x1 = data base, never rewritten
    emit_nops(3);
    for (int n = 0; n < n_instr; n++) begin
        kind = $urandom % 8;
        rd = 5'(2 + $urandom % 30);
        f3 = 3'($urandom);
        imm = 12'($urandom);
        case (kind)
            0, 1: begin
                if (f3 == 3'd1 || f3 == 3'd5)
                    imm = {1'b0, (f3 == 3'd5) & imm[10], 5'b0, imm[4:0]};
                emit_writer(enc_i(imm, 5'($urandom), f3, rd, 7'b0010011));
            end
            2: emit_writer({1'b0, (f3 == 3'd0 || f3 == 3'd5) & imm[0], 5'b0, 5'($urandom),
                            5'($urandom), f3, rd, 7'b0110011});
            3: emit_writer({20'($urandom), rd, imm[0] ? 7'b0110111 : 7'b0010111});
            4: begin
                f3 = imm[1] ? 3'd4 + 3'($urandom % 2) : 3'($urandom % 3);
                emit_writer(enc_i((12'($urandom % 256) >> f3[1:0]) << f3[1:0], 5'd1, f3,
                                  rd, 7'b0000011));
            end
            5: begin
                f3 = 3'($urandom % 3);
                emit(enc_s((12'($urandom % 256) >> f3) << f3, 5'($urandom), 5'd1, f3));
            end
            6: begin
                emit(enc_b(13'(4 * (7 + $urandom % 8)), 5'($urandom), 5'($urandom),
                           br_codes[$urandom % 6]));
                emit_shadow();
                emit_nops(8);  // landing pad under every branch target
            end
            default: begin
                if (imm[0]) begin
                    emit(enc_j(21'd28, rd));
                end else begin
                    // auipc base, its store, then jalr at +20 landing 28 past itself
                    emit_writer({20'h0, rd, 7'b0010111});
                    emit(enc_i(12'(48 + $urandom % 2), rd, 3'b000, 5'(2 + $urandom % 30),
                               7'b1100111));
                end
                emit_shadow();
                emit(enc_s(12'(4 * ($urandom % 64)), mem[gen_pos - 7][11:7], 5'd1, 3'b010));
            end
        endcase
    end
    emit_nops(16);
    loop_pc = 32'(gen_pos * 4);
    emit(enc_j(21'd0, 5'd0));  // self-loop
endtask

`endif

// File: tb/datapath_tb.sv
`timescale 1ns/1ps
`include "rv32i_settings.svh"

module datapath_tb;

    localparam int n_instr = 200;
    localparam int mem_words = 8192;
    localparam longint timeout_ns = longint'(n_instr) * 7 * 4 * 20 * 4;  // 4x margin

    logic        clk;
    logic        reset;
    logic        inst_read;
    logic [31:0] inst_addr;
    logic [31:0] inst_rdata;
    logic        inst_resp;
    logic        data_read;
    logic        data_write;
    logic [31:0] data_addr;
    logic [31:0] data_wdata;
    logic [3:0]  data_mbe;
    logic [31:0] data_rdata;
    logic        data_resp;
    logic        adv;

    logic [31:0] mem [0:mem_words-1];
    logic [31:0] ref_mem [0:mem_words-1];
    logic [31:0] ref_x [0:31];
    logic [31:0] exp_addr [$];
    logic [31:0] exp_data [$];
    logic [3:0]  exp_mbe [$];
    logic [31:0] exp_ld_addr [$];
    logic [3:0]  exp_ld_mbe [$];
    logic [31:0] loop_pc;
    int gen_pos;
    int errors;
    int stores_seen;
    int loads_seen;
    int exp_total;
    int inst_cnt;
    int data_cnt;

    `include "rv32i_ref_model.svh"

    datapath datapath_inst (
        .clk        (clk),
        .reset      (reset),
        .inst_read  (inst_read),
        .inst_addr  (inst_addr),
        .inst_rdata (inst_rdata),
        .inst_resp  (inst_resp),
        .data_read  (data_read),
        .data_write (data_write),
        .data_addr  (data_addr),
        .data_wdata (data_wdata),
        .data_mbe   (data_mbe),
        .data_rdata (data_rdata),
        .data_resp  (data_resp)
    );

    task automatic check_value(string name, logic [31:0] expected, logic [31:0] actual);
        if (expected !== actual) begin
            errors++;
            $display("[FAIL] %s expected %h actual %h", name, expected, actual);
        end
    endtask

    // byte enables from the access size and the address low bits
    function automatic logic [3:0] access_mbe(logic [1:0] size, logic [1:0] off);
        logic [3:0] base;
        case (size)
            2'd0:    base = 4'b0001;
            2'd1:    base = 4'b0011;
            default: base = 4'b1111;
        endcase
        return base << off;
    endfunction

    function automatic logic [31:0] ref_alu(logic [2:0] f3, logic alt, logic [31:0] a,
                                            logic [31:0] b);
        case (f3)
            3'd0:    return alt ? a - b : a + b;
            3'd1:    return a << b[4:0];
            3'd2:    return {31'b0, $signed(a) < $signed(b)};
            3'd3:    return {31'b0, a < b};
            3'd4:    return a ^ b;
            3'd5:    return alt ? 32'($signed(a) >>> b[4:0]) : a >> b[4:0];
            3'd6:    return a | b;
            default: return a & b;
        endcase
    endfunction

    function automatic logic branch_taken(logic [2:0] f3, logic [31:0] a, logic [31:0] b);
        case (f3)
            3'd0:    return a == b;
            3'd1:    return a != b;
            3'd4:    return $signed(a) < $signed(b);
            3'd5:    return $signed(a) >= $signed(b);
            3'd6:    return a < b;
            default: return a >= b;
        endcase
    endfunction

    // runs the program in order and queues every load and store it makes
    task automatic run_reference();
        logic [31:0] pc;
        logic [31:0] next;
        logic [31:0] inst;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] imm_i;
        logic [31:0] ea;
        logic [31:0] w;
        logic [31:0] res;
        logic [31:0] mask;
        logic [7:0]  lb;
        logic [15:0] lh;
        logic [3:0]  mbe;
        logic [2:0]  f3;
        logic        wr;
        int steps;
        pc = `RESET_PC;
        steps = 0;
        for (int i = 0; i < 32; i++)
            ref_x[i] = '0;
        while (pc != loop_pc && steps < 100000) begin
            inst = ref_mem[pc[14:2]];
            a = ref_x[inst[19:15]];
            b = ref_x[inst[24:20]];
            f3 = inst[14:12];
            imm_i = {{20{inst[31]}}, inst[31:20]};
            next = pc + 4;
            res = '0;
            wr = 1'b1;
            case (inst[6:0])
                7'h37: res = {inst[31:12], 12'h000};
                7'h17: res = pc + {inst[31:12], 12'h000};
                7'h6f: begin
                    res = pc + 4;
                    next = pc + {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
                end
                7'h67: begin
                    res = pc + 4;
                    next = (a + imm_i) & ~32'h1;
                end
                7'h63: begin
                    wr = 1'b0;
                    if (branch_taken(f3, a, b))
                        next = pc + {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
                end
                7'h03: begin
                    ea = a + imm_i;
                    w = ref_mem[ea[14:2]];
                    exp_ld_addr.push_back({ea[31:2], 2'b00});
                    exp_ld_mbe.push_back(access_mbe(f3[1:0], ea[1:0]));
                    lb = w[8*ea[1:0] +: 8];
                    lh = ea[1] ? w[31:16] : w[15:0];
                    case (f3)
                        3'd0:    res = {{24{lb[7]}}, lb};
                        3'd1:    res = {{16{lh[15]}}, lh};
                        3'd4:    res = {24'h0, lb};
                        3'd5:    res = {16'h0, lh};
                        default: res = w;
                    endcase
                end
                7'h23: begin
                    wr = 1'b0;
                    ea = a + {{20{inst[31]}}, inst[31:25], inst[11:7]};
                    mbe = access_mbe(f3[1:0], ea[1:0]);
                    mask = byte_mask(mbe);
                    w = (b << (8 * ea[1:0])) & mask;
                    exp_addr.push_back({ea[31:2], 2'b00});
                    exp_data.push_back(w);
                    exp_mbe.push_back(mbe);
                    ref_mem[ea[14:2]] = (ref_mem[ea[14:2]] & ~mask) | w;
                end
                7'h13: res = ref_alu(f3, (f3 == 3'd5) & inst[30], a, imm_i);
                7'h33: res = ref_alu(f3, inst[30], a, b);
                default: wr = 1'b0;
            endcase
            if (wr && inst[11:7] != 5'd0)
                ref_x[inst[11:7]] = res;
            pc = next;
            steps++;
        end
    endtask

    // one completed store, compared with the head of the model's stream
    task automatic commit_store();
        logic [31:0] mask;
        mask = byte_mask(data_mbe);
        if (exp_addr.size() == 0) begin
            errors++;
            $display("store to %h arrived after the expected stream ended", data_addr);
        end else begin
            check_value($sformatf("store %0d addr", stores_seen), exp_addr.pop_front(),
                        data_addr);
            check_value($sformatf("store %0d data", stores_seen), exp_data.pop_front(),
                        data_wdata & mask);
            check_value($sformatf("store %0d mbe", stores_seen), 32'(exp_mbe.pop_front()),
                        32'(data_mbe));
            stores_seen++;
        end
        mem[data_addr[14:2]] <= (mem[data_addr[14:2]] & ~mask) | (data_wdata & mask);
    endtask

    // one completed load request, compared with the model's next load
    task automatic check_load();
        if (exp_ld_addr.size() == 0) begin
            errors++;
            $display("load from %h arrived after the expected loads ended", data_addr);
        end else begin
            check_value($sformatf("load %0d addr", loads_seen), exp_ld_addr.pop_front(),
                        data_addr);
            check_value($sformatf("load %0d mbe", loads_seen), 32'(exp_ld_mbe.pop_front()),
                        32'(data_mbe));
            loads_seen++;
        end
    endtask

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    initial begin
        #(timeout_ns * 1ns);
        $display("timeout after %0d ns, %0d stores checked", timeout_ns, stores_seen);
        $display("ERRORS FOUND");
        $finish;
    end

    // advance as the DUT sees it during the cycle ending at this edge
    assign adv = inst_resp && (!(data_read || data_write) || data_resp);

    always @(posedge clk) begin
        if (reset) begin
            inst_resp <= 1'b0;
            data_resp <= 1'b0;
            inst_cnt  <= $urandom % 4;
            data_cnt  <= $urandom % 4;
        end else begin
            check_value("inst_read", 32'd1, 32'(inst_read));
            if (adv && data_write)
                commit_store();
            if (adv && data_read)
                check_load();
            if (adv) begin
                inst_resp <= 1'b0;
                inst_cnt  <= $urandom % 4;
            end else if (!inst_resp) begin
                if (inst_cnt == 0) begin
                    inst_resp  <= 1'b1;
                    inst_rdata <= mem[inst_addr[14:2]];
                end else begin
                    inst_cnt <= inst_cnt - 1;
                end
            end
            if (adv) begin
                data_resp <= 1'b0;
                data_cnt  <= $urandom % 4;
            end else if ((data_read || data_write) && !data_resp) begin
                if (data_cnt == 0) begin
                    data_resp  <= 1'b1;
                    data_rdata <= mem[data_addr[14:2]];
                end else begin
                    data_cnt <= data_cnt - 1;
                end
            end
        end
    end

    initial begin
        reset      = 1'b1;
        inst_rdata = '0;
        inst_resp  = 1'b0;
        data_rdata = '0;
        data_resp  = 1'b0;
        errors      = 0;
        stores_seen = 0;
        loads_seen  = 0;
        void'($urandom(69));
        for (int i = 0; i < mem_words; i++)
            mem[i] = fill_word(i);
        gen_program();
        for (int i = 0; i < mem_words; i++)
            ref_mem[i] = mem[i];
        run_reference();
        exp_total = exp_addr.size();
        repeat (2) @(posedge clk);
        reset <= 1'b0;
        #1;
        check_value("reset inst_addr", `RESET_PC, inst_addr);
        check_value("reset data_read", 32'd0, 32'(data_read));
        check_value("reset data_write", 32'd0, 32'(data_write));
        while (stores_seen < exp_total)
            @(posedge clk);
        repeat (100) @(posedge clk);  // catch stray stores past the end
        if (exp_ld_addr.size() != 0) begin
            errors++;
            $display("%0d expected loads never reached the data port", exp_ld_addr.size());
        end
        $display("summary: %0d errors, %0d of %0d stores checked, %0d loads checked",
                 errors, stores_seen, exp_total, loads_seen);
        if (errors == 0)
            $display("NO ERRORS");
        else
            $display("ERRORS FOUND");
        $finish;
    end

endmodule

// File: design/datapath.sv
`timescale 1ns/1ps
`include "rv32i_settings.svh"

module datapath (
    input  logic                   clk,
    input  logic                   reset,

    output logic                   inst_read,
    output rv32i_types::rv32i_word inst_addr,
    input  rv32i_types::rv32i_word inst_rdata,
    input  logic                   inst_resp,

    output logic                   data_read,
    output logic                   data_write,
    output rv32i_types::rv32i_word data_addr,
    output rv32i_types::rv32i_word data_wdata,
    output logic [3:0]             data_mbe,
    input  rv32i_types::rv32i_word data_rdata,
    input  logic                   data_resp
);
    import rv32i_types::*;
    import pipe_ctrl_types::*;

    logic       advance;
    logic       taken;  // resolved in mem, also the flush
    rv32i_word  pc;
    rv32i_word  pc_next;
    pcmux_sel_t pcmux_sel;

    rv32i_word         ir_id;
    rv32i_word         pc_id;
    rv32i_control_word ctrl_id;
    rv32i_word         rs1_data_id;
    rv32i_word         rs2_data_id;

    rv32i_control_word ctrl_ex;
    rv32i_word         pc_ex;
    rv32i_word         rs1_ex;
    rv32i_word         rs2_ex;
    rv32i_word         alu_a;
    rv32i_word         alu_b;
    rv32i_word         alu_f;
    logic              br_en;
    branch_funct3_t    cmpop;

    rv32i_control_word ctrl_mem;
    rv32i_word         pc_mem;
    rv32i_word         alu_mem;
    rv32i_word         rs2_mem;
    logic              br_en_mem;
    logic [3:0]        mbe_base;
    rv32i_word         load_value;

    rv32i_control_word ctrl_wb;
    rv32i_word         pc_wb;
    rv32i_word         alu_wb;
    logic              br_en_wb;
    rv32i_word         load_wb;
    rv32i_word         wb_value;

    // stall on fetch, or on an outstanding data access
    assign advance = inst_resp &
                     (~(ctrl_mem.mem_read | ctrl_mem.mem_write) | data_resp);

    assign inst_read = 1'b1;
    assign inst_addr = pc;

    assign taken = ctrl_mem.is_jal | ctrl_mem.is_jalr | (ctrl_mem.is_branch & br_en_mem);

    always_comb begin
        if (!taken)
            pcmux_sel = pc_plus4;
        else if (ctrl_mem.is_jalr)
            pcmux_sel = target_mod2;
        else
            pcmux_sel = target;

        case (pcmux_sel)
            pc_plus4:    pc_next = pc + 4;
            target:      pc_next = alu_mem;
            target_mod2: pc_next = {alu_mem[`XLEN-1:1], 1'b0};
            default:     pc_next = pc + 4;
        endcase
    end

    control_unit control_unit_inst (
        .inst      (ir_id),
        .ctrl_word (ctrl_id)
    );

    regfile regfile_inst (
        .clk      (clk),
        .reset    (reset),
        .load     (ctrl_wb.load_regfile & advance),  // held while stalled
        .rd       (ctrl_wb.rd),
        .rs1      (ir_id[19:15]),
        .rs2      (ir_id[24:20]),
        .wdata    (wb_value),
        .rs1_data (rs1_data_id),
        .rs2_data (rs2_data_id)
    );

    assign alu_a = (ctrl_ex.alumux1_sel == alumux1_pc)  ? pc_ex : rs1_ex;
    assign alu_b = (ctrl_ex.alumux2_sel == alumux2_imm) ? ctrl_ex.imm : rs2_ex;

    // branches use their own funct3, register slt/sltu map onto blt/bltu
    always_comb begin
        if (ctrl_ex.is_branch)
            cmpop = branch_funct3_t'(ctrl_ex.funct3);
        else if (ctrl_ex.funct3 == sltu)
            cmpop = bltu;
        else
            cmpop = blt;
    end

    alu alu_inst (
        .aluop    (ctrl_ex.aluop),
        .cmpop    (cmpop),
        .a        (alu_a),
        .b        (alu_b),
        .rs1_data (rs1_ex),
        .rs2_data (rs2_ex),
        .f        (alu_f),
        .br_en    (br_en)
    );

    assign data_read  = ctrl_mem.mem_read;
    assign data_write = ctrl_mem.mem_write;
    assign data_addr  = {alu_mem[`XLEN-1:2], 2'b00};
    assign data_wdata = rs2_mem << {alu_mem[1:0], 3'b000};

    // load sizes share the low two funct3 bits with store sizes
    always_comb begin
        case (store_funct3_t'({1'b0, ctrl_mem.funct3[1:0]}))
            sb:      mbe_base = 4'b0001;
            sh:      mbe_base = 4'b0011;
            default: mbe_base = 4'b1111;
        endcase
        data_mbe = mbe_base << alu_mem[1:0];
    end

    load_align load_align_inst (
        .funct3   (load_funct3_t'(ctrl_mem.funct3)),
        .byte_off (alu_mem[1:0]),
        .rdata    (data_rdata),
        .value    (load_value)
    );

    always_comb begin
        case (ctrl_wb.regfilemux_sel)
            rf_alu_out:  wb_value = alu_wb;
            rf_br_en:    wb_value = rv32i_word'(br_en_wb);
            rf_u_imm:    wb_value = ctrl_wb.imm;
            rf_load:     wb_value = load_wb;
            rf_pc_plus4: wb_value = pc_wb + 4;  // link value
            default:     wb_value = alu_wb;
        endcase
    end

    // control state, squashed on a taken control transfer
    always_ff @(posedge clk) begin
        if (reset) begin
            pc       <= `RESET_PC;
            ir_id    <= `NOP_INST;
            ctrl_ex  <= '0;
            ctrl_mem <= '0;
            ctrl_wb  <= '0;
        end else if (advance) begin
            pc      <= pc_next;
            ctrl_wb <= ctrl_mem;
            if (taken) begin
                ir_id    <= `NOP_INST;
                ctrl_ex  <= '0;
                ctrl_mem <= '0;
            end else begin
                ir_id    <= inst_rdata;
                ctrl_ex  <= ctrl_id;
                ctrl_mem <= ctrl_ex;
            end
        end
    end

    // payload, only meaningful alongside a live control word
    always_ff @(posedge clk) begin
        if (advance) begin
            pc_id     <= pc;
            pc_ex     <= pc_id;
            rs1_ex    <= rs1_data_id;
            rs2_ex    <= rs2_data_id;
            pc_mem    <= pc_ex;
            alu_mem   <= alu_f;
            rs2_mem   <= rs2_ex;
            br_en_mem <= br_en;
            pc_wb     <= pc_mem;
            alu_wb    <= alu_mem;
            br_en_wb  <= br_en_mem;
            load_wb   <= load_value;
        end
    end

endmodule

// File: design/load_align.sv
`timescale 1ns/1ps

module load_align (
    input  rv32i_types::load_funct3_t funct3,
    input  logic [1:0]                byte_off,
    input  rv32i_types::rv32i_word    rdata,
    output rv32i_types::rv32i_word    value
);
    import rv32i_types::*;

    logic [7:0]  lane_b;
    logic [15:0] lane_h;

    assign lane_b = rdata[8*byte_off +: 8];
    assign lane_h = byte_off[1] ? rdata[31:16] : rdata[15:0];  // halfwords are aligned

    always_comb begin
        case (funct3)
            lb:      value = {{24{lane_b[7]}}, lane_b};
            lbu:     value = {24'h000000, lane_b};
            lh:      value = {{16{lane_h[15]}}, lane_h};
            lhu:     value = {16'h0000, lane_h};
            lw:      value = rdata;
            default: value = rdata;
        endcase
    end

endmodule

// File: design/alu.sv
`timescale 1ns/1ps

module alu (
    input  rv32i_types::alu_ops         aluop,
    input  rv32i_types::branch_funct3_t cmpop,
    input  rv32i_types::rv32i_word      a,
    input  rv32i_types::rv32i_word      b,
    input  rv32i_types::rv32i_word      rs1_data,
    input  rv32i_types::rv32i_word      rs2_data,
    output rv32i_types::rv32i_word      f,
    output logic                        br_en
);
    import rv32i_types::*;

    always_comb begin
        case (aluop)
            alu_add:  f = a + b;
            alu_sub:  f = a - b;
            alu_sll:  f = a << b[4:0];
            alu_slt:  f = rv32i_word'($signed(a) < $signed(b));
            alu_sltu: f = rv32i_word'(a < b);
            alu_xor:  f = a ^ b;
            alu_srl:  f = a >> b[4:0];
            alu_sra:  f = rv32i_word'($signed(a) >>> b[4:0]);
            alu_or:   f = a | b;
            alu_and:  f = a & b;
            default:  f = a + b;
        endcase
    end

    // comparator always looks at the register values
    always_comb begin
        case (cmpop)
            beq:     br_en = (rs1_data == rs2_data);
            bne:     br_en = (rs1_data != rs2_data);
            blt:     br_en = ($signed(rs1_data) < $signed(rs2_data));
            bge:     br_en = ($signed(rs1_data) >= $signed(rs2_data));
            bltu:    br_en = (rs1_data < rs2_data);
            bgeu:    br_en = (rs1_data >= rs2_data);
            default: br_en = 1'b0;
        endcase
    end

endmodule

// File: design/regfile.sv
`timescale 1ns/1ps

module regfile (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  load,
    input  rv32i_types::rv32i_reg rd,
    input  rv32i_types::rv32i_reg rs1,
    input  rv32i_types::rv32i_reg rs2,
    input  rv32i_types::rv32i_word wdata,
    output rv32i_types::rv32i_word rs1_data,
    output rv32i_types::rv32i_word rs2_data
);
    import rv32i_types::*;

    rv32i_word regs [1:31];  // x0 has no storage

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 1; i < 32; i++)
                regs[i] <= '0;
        end else if (load && rd != 5'd0) begin
            regs[rd] <= wdata;
        end
    end

    // write-through so a reader in decode sees the writeback value
    always_comb begin
        if (rs1 == 5'd0)            rs1_data = '0;
        else if (load && rd == rs1) rs1_data = wdata;
        else                        rs1_data = regs[rs1];

        if (rs2 == 5'd0)            rs2_data = '0;
        else if (load && rd == rs2) rs2_data = wdata;
        else                        rs2_data = regs[rs2];
    end

endmodule

// File: design/control_unit.sv
`timescale 1ns/1ps

module control_unit (
    input  rv32i_types::rv32i_word              inst,
    output pipe_ctrl_types::rv32i_control_word  ctrl_word
);
    import rv32i_types::*;
    import pipe_ctrl_types::*;

    logic [2:0] funct3;
    rv32i_word  i_imm;
    rv32i_word  s_imm;
    rv32i_word  b_imm;
    rv32i_word  u_imm;
    rv32i_word  j_imm;
    alu_ops     arith_op;

    assign funct3 = inst[14:12];

    assign i_imm = {{21{inst[31]}}, inst[30:20]};
    assign s_imm = {{21{inst[31]}}, inst[30:25], inst[11:7]};
    assign b_imm = {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
    assign u_imm = {inst[31:12], 12'h000};
    assign j_imm = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};

    // shared by op_imm and op_reg
    always_comb begin
        case (arith_funct3_t'(funct3))
            add:     arith_op = alu_add;
            sll:     arith_op = alu_sll;
            slt:     arith_op = alu_slt;
            sltu:    arith_op = alu_sltu;
            axor:    arith_op = alu_xor;
            sr:      arith_op = inst[30] ? alu_sra : alu_srl;
            aor:     arith_op = alu_or;
            aand:    arith_op = alu_and;
            default: arith_op = alu_add;
        endcase
    end

    always_comb begin
        ctrl_word = '0;  // unknown opcodes stay cleared
        case (rv32i_opcode'(inst[6:0]))
            op_lui: begin
                ctrl_word.opcode         = op_lui;
                ctrl_word.load_regfile   = 1'b1;
                ctrl_word.regfilemux_sel = rf_u_imm;
                ctrl_word.imm            = u_imm;
            end
            op_auipc: begin
                ctrl_word.opcode       = op_auipc;
                ctrl_word.load_regfile = 1'b1;
                ctrl_word.alumux1_sel  = alumux1_pc;
                ctrl_word.alumux2_sel  = alumux2_imm;
                ctrl_word.imm          = u_imm;
            end
            op_jal: begin
                ctrl_word.opcode         = op_jal;
                ctrl_word.is_jal         = 1'b1;
                ctrl_word.load_regfile   = 1'b1;
                ctrl_word.regfilemux_sel = rf_pc_plus4;
                ctrl_word.alumux1_sel    = alumux1_pc;  // target = pc + j_imm
                ctrl_word.alumux2_sel    = alumux2_imm;
                ctrl_word.imm            = j_imm;
            end
            op_jalr: begin
                ctrl_word.opcode         = op_jalr;
                ctrl_word.is_jalr        = 1'b1;
                ctrl_word.load_regfile   = 1'b1;
                ctrl_word.regfilemux_sel = rf_pc_plus4;
                ctrl_word.alumux2_sel    = alumux2_imm;  // rs1 + i_imm
                ctrl_word.imm            = i_imm;
            end
            op_br: begin
                ctrl_word.opcode      = op_br;
                ctrl_word.is_branch   = 1'b1;
                ctrl_word.alumux1_sel = alumux1_pc;
                ctrl_word.alumux2_sel = alumux2_imm;
                ctrl_word.imm         = b_imm;
            end
            op_load: begin
                ctrl_word.opcode         = op_load;
                ctrl_word.mem_read       = 1'b1;
                ctrl_word.load_regfile   = 1'b1;
                ctrl_word.regfilemux_sel = rf_load;
                ctrl_word.alumux2_sel    = alumux2_imm;
                ctrl_word.imm            = i_imm;
            end
            op_store: begin
                ctrl_word.opcode      = op_store;
                ctrl_word.mem_write   = 1'b1;
                ctrl_word.alumux2_sel = alumux2_imm;
                ctrl_word.imm         = s_imm;
            end
            op_imm: begin
                ctrl_word.opcode       = op_imm;
                ctrl_word.load_regfile = 1'b1;
                ctrl_word.alumux2_sel  = alumux2_imm;
                ctrl_word.aluop        = arith_op;
                ctrl_word.imm          = i_imm;
            end
            op_reg: begin
                ctrl_word.opcode       = op_reg;
                ctrl_word.load_regfile = 1'b1;
                ctrl_word.aluop        = arith_op;
                if (funct3 == add && inst[30])
                    ctrl_word.aluop = alu_sub;
                // register slt/sltu come from the comparator
                if (funct3 == slt || funct3 == sltu)
                    ctrl_word.regfilemux_sel = rf_br_en;
            end
            default: ;
        endcase
        if (ctrl_word.opcode != rv32i_opcode'(7'b0)) begin
            ctrl_word.funct3 = funct3;
            if (ctrl_word.load_regfile)
                ctrl_word.rd = inst[11:7];
        end
    end

endmodule

// File: design/pipe_ctrl_types.sv
package pipe_ctrl_types;

    import rv32i_types::*;

    // next pc source
    typedef enum logic [1:0] {
        pc_plus4    = 2'b00,
        target      = 2'b01,
        target_mod2 = 2'b10  // jalr, low bit cleared
    } pcmux_sel_t;

    typedef enum logic {
        alumux1_rs1 = 1'b0,
        alumux1_pc  = 1'b1
    } alumux1_sel_t;

    typedef enum logic {
        alumux2_rs2 = 1'b0,
        alumux2_imm = 1'b1
    } alumux2_sel_t;

    // writeback value source
    typedef enum logic [2:0] {
        rf_alu_out  = 3'b000,
        rf_br_en    = 3'b001,
        rf_u_imm    = 3'b010,
        rf_load     = 3'b011,
        rf_pc_plus4 = 3'b100
    } regfilemux_sel_t;

    // travels with the instruction from decode to writeback
    typedef struct packed {
        rv32i_opcode     opcode;
        logic [2:0]      funct3;
        alu_ops          aluop;
        alumux1_sel_t    alumux1_sel;
        alumux2_sel_t    alumux2_sel;
        regfilemux_sel_t regfilemux_sel;
        logic            mem_read;
        logic            mem_write;
        logic            load_regfile;
        rv32i_reg        rd;
        logic            is_branch;
        logic            is_jal;
        logic            is_jalr;
        rv32i_word       imm;
    } rv32i_control_word;

endpackage

// File: design/rv32i_types.sv
`include "rv32i_settings.svh"

package rv32i_types;

    typedef logic [`XLEN-1:0] rv32i_word;
    typedef logic [4:0] rv32i_reg;

    // major opcodes, bits [6:0]
    typedef enum logic [6:0] {
        op_lui   = 7'b0110111,
        op_auipc = 7'b0010111,
        op_jal   = 7'b1101111,
        op_jalr  = 7'b1100111,
        op_br    = 7'b1100011,
        op_load  = 7'b0000011,
        op_store = 7'b0100011,
        op_imm   = 7'b0010011,
        op_reg   = 7'b0110011
    } rv32i_opcode;

    typedef enum logic [2:0] {
        beq  = 3'b000,
        bne  = 3'b001,
        blt  = 3'b100,
        bge  = 3'b101,
        bltu = 3'b110,
        bgeu = 3'b111
    } branch_funct3_t;

    typedef enum logic [2:0] {
        lb  = 3'b000,
        lh  = 3'b001,
        lw  = 3'b010,
        lbu = 3'b100,
        lhu = 3'b101
    } load_funct3_t;

    typedef enum logic [2:0] {
        sb = 3'b000,
        sh = 3'b001,
        sw = 3'b010
    } store_funct3_t;

    typedef enum logic [2:0] {
        add  = 3'b000,
        sll  = 3'b001,
        slt  = 3'b010,
        sltu = 3'b011,
        axor = 3'b100,
        sr   = 3'b101,  // srl or sra, picked by bit 30
        aor  = 3'b110,
        aand = 3'b111
    } arith_funct3_t;

    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_sll,
        alu_slt,
        alu_sltu,
        alu_xor,
        alu_srl,
        alu_sra,
        alu_or,
        alu_and
    } alu_ops;

endpackage

// File: design/rv32i_settings.svh
`ifndef RV32I_SETTINGS_SVH
`define RV32I_SETTINGS_SVH

// data path width for RV32I
`define XLEN 32

// first fetch address after reset
`define RESET_PC 32'h0000_0000

// addi x0, x0, 0
// a squashed fetch/decode register holds this value
`define NOP_INST 32'h0000_0013

`endif
